/* compile.f */
source/csr_pkg.sv
source/csr_access.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_unit.sv
testbench/csr_checker.sv
testbench/csr_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f --top-module csr_tb \
    --Mdir obj_dir -o csr_sim

./obj_dir/csr_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

/* source/csr_access.sv */
//======================================================================
// Bus front end of the CSR unit
// Address decode, command issue, read-data mux, ack and error flags
//======================================================================
module csr_access (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  csr_pkg::csr_addr_t        addr_i,
    input  csr_pkg::xlen_t            data_i,
    input  logic                      we_i,
    input  logic                      stb_i,
    input  logic                      cyc_i,
    input  csr_pkg::trap_view_t       trap_view_i,
    input  csr_pkg::counter_view_t    counter_view_i,
    output csr_pkg::csr_cmd_t         cmd_o,
    output logic                      ack_o,
    output logic                      err_o,
    output csr_pkg::xlen_t            data_o
);

    import csr_pkg::*;

    logic     ack_flag;   // Held while stb_i stays high
    logic     err_flag;
    logic     take;       // Request accepted this cycle
    csr_sel_e sel;
    xlen_t    rd_data;

    // Completion visible only while the master keeps the strobe up
    assign ack_o = ack_flag & stb_i;
    assign err_o = err_flag & stb_i;

    assign take = stb_i & cyc_i & ~ack_o & ~err_o;

    //==================================================================
    // Address decode
    //==================================================================
    always_comb begin
        case (addr_i)
            CSR_MISA:          sel = SEL_MISA;
            CSR_MSTATUS:       sel = SEL_MSTATUS;
            CSR_MSTATUSH:      sel = SEL_MSTATUSH;
            CSR_MIE:           sel = SEL_MIE;
            CSR_MIP:           sel = SEL_MIP;
            CSR_MTVEC:         sel = SEL_MTVEC;
            CSR_MEPC:          sel = SEL_MEPC;
            CSR_MCAUSE:        sel = SEL_MCAUSE;
            CSR_MTVAL:         sel = SEL_MTVAL;
            CSR_MSCRATCH:      sel = SEL_MSCRATCH;
            CSR_MTINST:        sel = SEL_MTINST;
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID, CSR_MCONFIGPTR, CSR_MTVAL2:
                               sel = SEL_ZERO;    // Read as zero, writes dropped
            CSR_ENTER_TRAP:    sel = SEL_ENTER_TRAP;
            CSR_EXIT_TRAP:     sel = SEL_EXIT_TRAP;
            CSR_MCYCLE:        sel = SEL_MCYCLE;
            CSR_MCYCLEH:       sel = SEL_MCYCLEH;
            CSR_MINSTRET:      sel = SEL_MINSTRET;
            CSR_MINSTRETH:     sel = SEL_MINSTRETH;
            CSR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
            default:           sel = SEL_NONE;    // Unsupported, ends in error
        endcase
    end

    // Command to the register blocks
    assign cmd_o.valid = take;
    assign cmd_o.we    = we_i;
    assign cmd_o.sel   = sel;
    assign cmd_o.wdata = data_i;

    //==================================================================
    // Read mux
    //==================================================================
    always_comb begin
        case (sel)
            SEL_MISA:          rd_data = trap_view_i.misa;
            SEL_MSTATUS:       rd_data = trap_view_i.mstatus;
            SEL_MSTATUSH:      rd_data = trap_view_i.mstatush;
            SEL_MIE:           rd_data = trap_view_i.mie;
            SEL_MIP:           rd_data = trap_view_i.mip;
            SEL_MTVEC:         rd_data = trap_view_i.mtvec;
            SEL_MEPC:          rd_data = trap_view_i.mepc;
            SEL_MCAUSE:        rd_data = trap_view_i.mcause;
            SEL_MTVAL:         rd_data = trap_view_i.mtval;
            SEL_MSCRATCH:      rd_data = trap_view_i.mscratch;
            SEL_MTINST:        rd_data = trap_view_i.mtinst;
            SEL_ENTER_TRAP:    rd_data = trap_view_i.trap_target;
            SEL_EXIT_TRAP:     rd_data = trap_view_i.mepc;  // Return address
            SEL_MCYCLE:        rd_data = counter_view_i.mcycle[31:0];
            SEL_MCYCLEH:       rd_data = counter_view_i.mcycle[63:32];
            SEL_MINSTRET:      rd_data = counter_view_i.minstret[31:0];
            SEL_MINSTRETH:     rd_data = counter_view_i.minstret[63:32];
            SEL_MCOUNTINHIBIT: rd_data = counter_view_i.mcountinhibit;
            default:           rd_data = '0;  // Zero group and errors
        endcase
    end

    //==================================================================
    // Completion flags and read data
    //==================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_flag <= 1'b0;
            err_flag <= 1'b0;
        end else if (take) begin
            ack_flag <= (sel != SEL_NONE);
            err_flag <= (sel == SEL_NONE);
        end else begin
            // Drop on the first edge with stb_i low
            if (ack_flag) ack_flag <= stb_i;
            if (err_flag) err_flag <= stb_i;
        end
    end

    // Writes return the old value, much like csrrw
    always_ff @(posedge clk_i) begin
        if (take) data_o <= rd_data;
    end

endmodule

/* source/csr_counters.sv */
//======================================================================
// mcycle and minstret 64-bit counters with mcountinhibit
//======================================================================
module csr_counters (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  csr_pkg::csr_cmd_t       cmd_i,
    input  logic                    retire_i,
    output csr_pkg::counter_view_t  view_o
);

    import csr_pkg::*;

    counter_t mcycle;
    counter_t minstret;
    xlen_t    mcountinhibit;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle        <= '0;
            minstret      <= '0;
            mcountinhibit <= '0;  // All counters running
        end else begin
            // Only the inhibit register is writable here
            if (cmd_i.valid && cmd_i.we && cmd_i.sel == SEL_MCOUNTINHIBIT)
                mcountinhibit <= cmd_i.wdata;

            if (!mcountinhibit[INHIBIT_CY_BIT])
                mcycle <= mcycle + 64'd1;                // Every clock
            if (retire_i && !mcountinhibit[INHIBIT_IR_BIT])
                minstret <= minstret + 64'd1;            // Per retired instr
        end
    end

    assign view_o.mcycle        = mcycle;
    assign view_o.minstret      = minstret;
    assign view_o.mcountinhibit = mcountinhibit;

endmodule

/* source/csr_pkg.sv */
//======================================================================
// Shared definitions of the machine-mode CSR unit
// Widths, CSR addresses, reset values and bit positions
// Register select enum, command and read-view structs
//======================================================================
package csr_pkg;

    typedef logic [31:0] xlen_t;      // Data word
    typedef logic [11:0] csr_addr_t;  // CSR address
    typedef logic [63:0] counter_t;   // Full counter value

    //==================================================================
    // CSR addresses
    //==================================================================
    localparam csr_addr_t CSR_MSTATUS       = 12'h300;
    localparam csr_addr_t CSR_MISA          = 12'h301;
    localparam csr_addr_t CSR_MIE           = 12'h304;
    localparam csr_addr_t CSR_MTVEC         = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH      = 12'h310;
    localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
    localparam csr_addr_t CSR_MEPC          = 12'h341;
    localparam csr_addr_t CSR_MCAUSE        = 12'h342;
    localparam csr_addr_t CSR_MTVAL         = 12'h343;
    localparam csr_addr_t CSR_MIP           = 12'h344;
    localparam csr_addr_t CSR_MTINST        = 12'h34a;
    localparam csr_addr_t CSR_MTVAL2        = 12'h34b;
    localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
    localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
    localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;
    localparam csr_addr_t CSR_MVENDORID     = 12'hf11;
    localparam csr_addr_t CSR_MARCHID       = 12'hf12;
    localparam csr_addr_t CSR_MIMPID        = 12'hf13;
    localparam csr_addr_t CSR_MHARTID       = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR    = 12'hf15;
    localparam csr_addr_t CSR_ENTER_TRAP    = 12'h7c0;  // Custom, returns handler
    localparam csr_addr_t CSR_EXIT_TRAP     = 12'h7c1;  // Custom, returns mepc

    // Bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int INHIBIT_CY_BIT   = 0;
    localparam int INHIBIT_IR_BIT   = 2;

    // Reset values
    localparam xlen_t MISA_RESET   = 32'h4000_0100;  // MXL=1, I only
    localparam xlen_t INVALID_ADDR = 32'hffff_ffff;  // mtvec not yet set

    // Interrupt causes, bit 31 set
    localparam xlen_t IRQ_SOFTWARE = 32'h8000_0003;
    localparam xlen_t IRQ_TIMER    = 32'h8000_0007;
    localparam xlen_t IRQ_EXTERNAL = 32'h8000_000b;

    localparam logic [1:0] MTVEC_VECTORED = 2'd1;  // mtvec mode field

    // Decoded register select
    typedef enum logic [4:0] {
        SEL_NONE, SEL_MISA, SEL_MSTATUS, SEL_MSTATUSH, SEL_MIE, SEL_MIP,
        SEL_MTVEC, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MSCRATCH, SEL_MTINST,
        SEL_ZERO, SEL_ENTER_TRAP, SEL_EXIT_TRAP, SEL_MCYCLE, SEL_MCYCLEH,
        SEL_MINSTRET, SEL_MINSTRETH, SEL_MCOUNTINHIBIT
    } csr_sel_e;

    typedef struct packed {
        logic     valid;  // One cycle per accepted request
        logic     we;
        csr_sel_e sel;
        xlen_t    wdata;
    } csr_cmd_t;

    typedef struct packed {
        xlen_t misa;
        xlen_t mstatus;
        xlen_t mstatush;
        xlen_t mie;
        xlen_t mip;
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mtval;
        xlen_t mscratch;
        xlen_t mtinst;
        xlen_t trap_target;  // Handler address for trap entry
    } trap_view_t;

    typedef struct packed {
        counter_t mcycle;
        counter_t minstret;
        xlen_t    mcountinhibit;
    } counter_view_t;

endpackage

/* source/csr_trap_regs.sv */
//======================================================================
// Machine status, trap and interrupt registers
// Trap entry and exit handling, mip latching, handler target select
//======================================================================
module csr_trap_regs (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  csr_pkg::csr_cmd_t     cmd_i,
    input  csr_pkg::xlen_t        io_irq_i,
    output csr_pkg::xlen_t        io_irq_o,
    output csr_pkg::trap_view_t   view_o
);

    import csr_pkg::*;

    xlen_t misa, mstatus, mstatush, mie, mip, mtvec;
    xlen_t mepc, mcause, mtval, mscratch, mtinst;
    xlen_t mip_base;      // mip after a bus write
    xlen_t mip_next;
    xlen_t mtvec_base;
    xlen_t trap_target;
    logic  wr;            // Bus write this cycle
    logic  is_irq_cause;

    assign wr = cmd_i.valid & cmd_i.we;

    // Pending interrupts hidden while MIE is clear
    assign io_irq_o = mstatus[MSTATUS_MIE_BIT] ? mip : '0;

    //==================================================================
    // Interrupt latching
    //==================================================================
    always_comb begin
        mip_base = (wr && cmd_i.sel == SEL_MIP) ? cmd_i.wdata : mip;
        if (mstatus[MSTATUS_MIE_BIT])
            mip_next = mip_base | (io_irq_i & mie);  // Only enabled sources
        else
            mip_next = mip_base;
    end

    //==================================================================
    // Handler address
    //==================================================================
    assign mtvec_base   = {mtvec[31:2], 2'b00};
    assign is_irq_cause = (mcause == IRQ_SOFTWARE) || (mcause == IRQ_TIMER) ||
                          (mcause == IRQ_EXTERNAL);

    always_comb begin
        if (mtvec[1:0] == MTVEC_VECTORED && is_irq_cause)
            trap_target = mtvec_base + {mcause[29:0], 2'b00};  // base + 4*code
        else
            trap_target = mtvec_base;  // Direct mode and exceptions
    end

    //==================================================================
    // Register updates
    //==================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            misa     <= MISA_RESET;
            mstatus  <= '0;            // MIE and MPIE clear
            mstatush <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= INVALID_ADDR;  // No handler set yet
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
            mtinst   <= '0;
        end else begin
            mip <= mip_next;
            if (cmd_i.valid) begin
                case (cmd_i.sel)
                    SEL_MISA:     if (cmd_i.we) misa <= cmd_i.wdata;
                    SEL_MSTATUS:  if (cmd_i.we) mstatus <= cmd_i.wdata;
                    SEL_MSTATUSH: if (cmd_i.we) mstatush <= cmd_i.wdata;
                    SEL_MIE:      if (cmd_i.we) mie <= cmd_i.wdata;
                    SEL_MTVEC:    if (cmd_i.we) mtvec <= cmd_i.wdata;
                    SEL_MEPC:     if (cmd_i.we) mepc <= cmd_i.wdata;
                    SEL_MCAUSE:   if (cmd_i.we) mcause <= cmd_i.wdata;
                    SEL_MTVAL:    if (cmd_i.we) mtval <= cmd_i.wdata;
                    SEL_MSCRATCH: if (cmd_i.we) mscratch <= cmd_i.wdata;
                    SEL_MTINST:   if (cmd_i.we) mtinst <= cmd_i.wdata;
                    SEL_ENTER_TRAP: begin
                        // Save MIE, then block nested interrupts
                        mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                        mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
                    end
                    SEL_EXIT_TRAP: begin
                        mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                        mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
                    end
                    default: ;  // Not a trap register
                endcase
            end
        end
    end

    // Read view
    assign view_o.misa        = misa;
    assign view_o.mstatus     = mstatus;
    assign view_o.mstatush    = mstatush;
    assign view_o.mie         = mie;
    assign view_o.mip         = mip;
    assign view_o.mtvec       = mtvec;
    assign view_o.mepc        = mepc;
    assign view_o.mcause      = mcause;
    assign view_o.mtval       = mtval;
    assign view_o.mscratch    = mscratch;
    assign view_o.mtinst      = mtinst;
    assign view_o.trap_target = trap_target;

endmodule

/* source/csr_unit.sv */
//======================================================================
// Top level of the machine-mode CSR unit
// Bus front end, trap registers and counters
//======================================================================
module csr_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      data_i,
    input  logic                we_i,
    input  logic                stb_i,
    input  logic                cyc_i,
    output logic                ack_o,
    output logic                err_o,
    output csr_pkg::xlen_t      data_o,
    input  logic                retire_i,
    input  csr_pkg::xlen_t      io_irq_i,
    output csr_pkg::xlen_t      io_irq_o
);

    import csr_pkg::*;

    csr_cmd_t      cmd;           // Shared by both register blocks
    trap_view_t    trap_view;
    counter_view_t counter_view;

    csr_access u_access (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .addr_i         (addr_i),
        .data_i         (data_i),
        .we_i           (we_i),
        .stb_i          (stb_i),
        .cyc_i          (cyc_i),
        .trap_view_i    (trap_view),
        .counter_view_i (counter_view),
        .cmd_o          (cmd),
        .ack_o          (ack_o),
        .err_o          (err_o),
        .data_o         (data_o)
    );

    csr_trap_regs u_trap_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cmd_i    (cmd),
        .io_irq_i (io_irq_i),
        .io_irq_o (io_irq_o),
        .view_o   (trap_view)
    );

    csr_counters u_counters (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cmd_i    (cmd),
        .retire_i (retire_i),
        .view_o   (counter_view)
    );

endmodule

/* testbench/csr_checker.sv */
//======================================================================
// Completion monitor of the CSR unit testbench
// Compares err_o, ack_o, data_o and io_irq_o with the vector file
//======================================================================
module csr_checker (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            ack_i,
    input  logic            err_i,
    input  csr_pkg::xlen_t  data_i,
    input  csr_pkg::xlen_t  irq_i,
    output int              checks_o,
    output int              errors_o,
    output int              completions_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    int    fd, checks, errors, completions;
    string line;
    logic  done_q;      // Completion seen at the previous edge
    logic  rst_q;
    xlen_t prev_data;   // data_o of the previous read

    assign checks_o      = checks;
    assign errors_o      = errors;
    assign completions_o = completions;

    initial begin
        checks      = 0;
        errors      = 0;
        completions = 0;
        done_q      = 1'b0;
        rst_q       = 1'b0;
        prev_data   = '0;
        fd = $fopen("testbench/csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("Monitor could not open the vector file");
            errors++;
        end
    end

    task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected 0x%08h, got 0x%08h at %0t", name, exp, got, $time);
        end
    endtask

    // Operation and expected fields of the next vector line
    task automatic next_expected(output logic found, output logic [7:0] op,
                                 output logic [7:0] kind, output xlen_t data,
                                 output int err, output xlen_t irq);
        csr_addr_t  addr;
        xlen_t      wdata, irq_in;
        int         retires;
        found = 1'b0;
        while (!found && fd != 0 && !$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
                found = ($sscanf(line, "%c %h %h %d %h %c %h %d %h", op, addr, wdata,
                                 retires, irq_in, kind, data, err, irq) == 9);
        end
    endtask

    //==================================================================
    // Compare on each new completion
    //==================================================================
    always @(posedge clk_i) begin
        logic       found;
        logic [7:0] op;
        logic [7:0] kind;
        xlen_t      exp_data, exp_irq;
        int         exp_err;
        if (rst_q && !rst_i) begin           // Idle bus right after reset
            compare_word("ack_o", {31'b0, ack_i}, '0);
            compare_word("err_o", {31'b0, err_i}, '0);
            compare_word("io_irq_o", irq_i, '0);
        end
        if ((ack_i || err_i) && !done_q && !rst_i) begin
            completions++;
            next_expected(found, op, kind, exp_data, exp_err, exp_irq);
            if (!found) begin
                $display("Completion at %0t has no vector left to compare", $time);
                errors++;
            end else begin
                compare_word("err_o", {31'b0, err_i}, xlen_t'(exp_err));
                compare_word("ack_o", {31'b0, ack_i}, {31'b0, exp_err == 0});
                checks++;
                case (kind)
                    "E": begin
                        checks--;                // Counted by compare_word
                        compare_word("data_o", data_i, exp_data);
                    end
                    "S": if (data_i !== prev_data) begin
                        errors++;
                        $display("Error: data_o 0x%08h differs from previous read 0x%08h",
                                 data_i, prev_data);
                    end
                    "G": if (!(data_i > prev_data)) begin
                        errors++;
                        $display("Error: data_o 0x%08h not above previous read 0x%08h",
                                 data_i, prev_data);
                    end
                    default: begin
                        errors++;
                        $display("Vector %0d has an unknown check kind", completions);
                    end
                endcase
                compare_word("io_irq_o", irq_i, exp_irq);
                if (op == "R")
                    prev_data = data_i;          // Reference for later S and G
            end
        end
        done_q = ack_i | err_i;
        rst_q  = rst_i;
    end

endmodule

/* testbench/csr_tb.sv */
//======================================================================
// Top-level testbench of the machine-mode CSR unit
// Clock, reset, vector-driven bus requests, DUT and monitor
//======================================================================
module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;  // Completion is due one cycle after take

    logic       clk, rst;
    csr_addr_t  addr;
    xlen_t      wdata, rdata;
    logic       we, stb, cyc, ack, err, retire;
    xlen_t      irq_in, irq_out;

    int         fd, issued, timeouts, checks, errors, completions;
    logic       timed_out;
    string      line;
    logic [7:0] op, kind;            // Kind is only used by the monitor
    csr_addr_t  v_addr;
    xlen_t      v_wdata, v_irq, exp_data, exp_irq;
    int         v_retires, exp_err;

    always #4 clk = ~clk;            // 8 ns period

    csr_unit DUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .addr_i   (addr),
        .data_i   (wdata),
        .we_i     (we),
        .stb_i    (stb),
        .cyc_i    (cyc),
        .ack_o    (ack),
        .err_o    (err),
        .data_o   (rdata),
        .retire_i (retire),
        .io_irq_i (irq_in),
        .io_irq_o (irq_out)
    );

    csr_checker u_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .ack_i         (ack),
        .err_i         (err),
        .data_i        (rdata),
        .irq_i         (irq_out),
        .checks_o      (checks),
        .errors_o      (errors),
        .completions_o (completions)
    );

    //==================================================================
    // One bus request, with its interrupt pulse and retire pulses first
    //==================================================================
    task automatic run_request();
        int cycles;
        irq_in = v_irq;              // One-cycle pulse
        @(negedge clk);
        irq_in = '0;
        repeat (v_retires) begin
            retire = 1'b1;
            @(negedge clk);
        end
        retire = 1'b0;
        addr   = v_addr;
        wdata  = v_wdata;
        we     = (op == "W");
        stb    = 1'b1;
        cyc    = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(ack || err) && cycles < TIMEOUT_CYCLES);
        if (!(ack || err)) begin
            $display("Timeout: request %0d to address 0x%03h never completed", issued, v_addr);
            timeouts++;
            timed_out = 1'b1;
        end
        @(negedge clk);              // Strobe held a cycle, completion seen at a rising edge
        stb = 1'b0;
        cyc = 1'b0;
        we  = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        addr      = '0;
        wdata     = '0;
        we        = 1'b0;
        stb       = 1'b0;
        cyc       = 1'b0;
        retire    = 1'b0;
        irq_in    = '0;
        issued    = 0;
        timeouts  = 0;
        timed_out = 1'b0;
        fd = $fopen("testbench/csr_vectors.txt", "r");
        repeat (10) @(negedge clk);
        rst = 1'b0;

        if (fd == 0) begin
            $display("Could not open the vector file");
        end else begin
            while (!timed_out && !$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    if ($sscanf(line, "%c %h %h %d %h %c %h %d %h", op, v_addr, v_wdata,
                                v_retires, v_irq, kind, exp_data, exp_err, exp_irq) == 9) begin
                        run_request();
                        issued++;
                    end
                end
            end
            $fclose(fd);
        end

        @(negedge clk);
        if (completions != issued)
            $display("Monitor saw %0d completions for %0d requests", completions, issued);
        $display("Requests: %0d, checks: %0d, errors: %0d, timeouts: %0d",
                 issued, checks, errors, timeouts);
        if (fd != 0 && issued > 0 && timeouts == 0 && errors == 0 && completions == issued)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* testbench/csr_vectors.txt */
# op addr wdata retires irq_in kind exp_data exp_err exp_irq_out
# op R read, W write; kind E exact, S same as previous, G greater than previous
R 301 00000000 0 00000000 E 40000100 0 00000000
R 305 00000000 0 00000000 E ffffffff 0 00000000
W 340 12345678 0 00000000 E 00000000 0 00000000
R 340 00000000 0 00000000 E 12345678 0 00000000
W 341 00000abc 0 00000000 E 00000000 0 00000000
R 341 00000000 0 00000000 E 00000abc 0 00000000
W 343 deadbeef 0 00000000 E 00000000 0 00000000
R 343 00000000 0 00000000 E deadbeef 0 00000000
W 304 00000080 0 00000000 E 00000000 0 00000000
R 304 00000000 0 00000000 E 00000080 0 00000000
R f14 00000000 0 00000000 E 00000000 0 00000000
R 7ff 00000000 0 00000000 E 00000000 1 00000000
W 7ff 11111111 0 00000000 E 00000000 1 00000000
R b02 00000000 5 00000000 E 00000005 0 00000000
R b00 00000000 0 00000000 G 00000000 0 00000000
W b00 00000000 0 00000000 G 00000000 0 00000000
R b00 00000000 0 00000000 G 00000000 0 00000000
W 320 00000005 0 00000000 E 00000000 0 00000000
R b00 00000000 0 00000000 G 00000000 0 00000000
R b00 00000000 0 00000000 S 00000000 0 00000000
R b02 00000000 3 00000000 E 00000005 0 00000000
R 320 00000000 0 00000000 E 00000005 0 00000000
W 305 00001000 0 00000000 E ffffffff 0 00000000
W 342 80000007 0 00000000 E 00000000 0 00000000
R 7c0 00000000 0 00000000 E 00001000 0 00000000
W 305 00001001 0 00000000 E 00001000 0 00000000
R 7c0 00000000 0 00000000 E 0000101c 0 00000000
W 342 8000000b 0 00000000 E 80000007 0 00000000
R 7c0 00000000 0 00000000 E 0000102c 0 00000000
R 7c1 00000000 0 00000000 E 00000abc 0 00000000
W 300 00000008 0 00000000 E 00000080 0 00000000
R 344 00000000 0 00000180 E 00000080 0 00000080
R 300 00000000 0 00000000 E 00000008 0 00000080
R 7c0 00000000 0 00000000 E 0000102c 0 00000000
R 300 00000000 0 00000000 E 00000080 0 00000000
R 344 00000000 0 00000000 E 00000080 0 00000000
